//--- sources.f
source/cpu9_pkg.sv
source/sync_ram.sv
source/alu.sv
source/register_file.sv
source/cpu9_core.sv
source/host_regs.sv
source/cpu9_top.sv
tests/cpu9_tb_sva.sv
tests/cpu9_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -j 0 --top-module cpu9_tb -f sources.f \
    && ./obj_dir/Vcpu9_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

//--- tests/cpu9_tb.sv
`timescale 1ns/100ps

module cpu9_tb;

    import cpu9_pkg::*;

    logic              clk;
    logic              rst;
    logic [AXI_AW-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [AXI_DW-1:0] wdata;
    logic [3:0]        wstrb;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [AXI_AW-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [AXI_DW-1:0] rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;
    logic              done;

    int          cycles;
    int          timeout_limit; // Longest program x3 plus AXI traffic
    int          errors;
    int          test_errors;   // Failures in the current test
    int          checks;
    int          tests;
    int          failed_tests;
    int          total_errors;
    logic [31:0] rng;           // Xorshift state
    logic [31:0] rd;
    logic [1:0]  resp;
    logic [5:0]  x_imm;
    logic [5:0]  y_imm;
    instr_t      prog [$];      // Program under test
    data_t       model_regs [4];
    data_t       model_mem [256];
    data_t       hw_regs [4];   // Last DUT readback

    cpu9_top cpu9_top_i (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .done    (done)
    );

    always #4 clk = ~clk; // 8 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout after %0d cycles, DUT never finished", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic data_t sign_extend(input logic [5:0] v);
        return {{2{v[5]}}, v};
    endfunction

    function automatic instr_t encode_reg(input opcode_t op, input logic [1:0] a,
                                          input logic [1:0] b);
        return {op, a, b, 2'b00};
    endfunction

    function automatic instr_t encode_imm(input opcode_t op, input logic [5:0] imm);
        return {op, imm};
    endfunction

    task automatic copy_r1_to(input logic [1:0] dst);
        prog.push_back(encode_reg(OP_STORE, 2'd0, 2'd1)); // mem[r0] = r1
        prog.push_back(encode_reg(OP_LOAD, 2'd0, dst));   // rdst = mem[r0]
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [31:0] data,
                             output logic [1:0] r);
        @(posedge clk);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (awready !== 1'b1 || wready !== 1'b1) @(negedge clk);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (bvalid !== 1'b1) @(negedge clk);
        @(posedge clk);
        #1;
        bready = 1'b1; // Response waits one cycle first
        @(negedge clk);
        r = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [31:0] data,
                            output logic [1:0] r);
        @(posedge clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (arready !== 1'b1) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (rvalid !== 1'b1) @(negedge clk);
        @(posedge clk);
        #1;
        rready = 1'b1; // Held off one cycle
        @(negedge clk);
        data = rdata;
        r    = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic load_program();
        logic [1:0] r;
        axi_write(REG_PADDR, 32'd0, r);
        expect_equal("bresp", 32'(RESP_OKAY), 32'(r));
        foreach (prog[i]) begin
            axi_write(REG_PDATA, 32'(prog[i]), r);
            expect_equal("bresp", 32'(RESP_OKAY), 32'(r));
        end
    endtask

    task automatic start_run();
        logic [1:0] r;
        axi_write(REG_CTRL, 32'd1, r);
        expect_equal("bresp", 32'(RESP_OKAY), 32'(r));
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (done !== 1'b1) @(negedge clk); // Bounded by the cycle counter
    endtask

    // Instruction-level model, registers and memory persist across runs
    task automatic run_model();
        logic [PC_W-1:0] pc;
        logic [PC_W-1:0] next_pc;
        instr_t          w;
        logic [1:0]      ra;
        logic [1:0]      rb;
        logic            halted;
        int              steps;
        pc     = '0;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 256) begin
            w       = prog[pc];
            ra      = w[5:4];
            rb      = w[3:2];
            next_pc = pc + 8'd1;
            case (opcode_t'(w[8:6]))
                OP_ADD:   model_regs[1] = model_regs[ra] + model_regs[rb];
                OP_SUB:   model_regs[1] = model_regs[ra] - model_regs[rb];
                OP_AND:   model_regs[1] = model_regs[ra] & model_regs[rb];
                OP_SHL:   model_regs[1] = model_regs[ra] << model_regs[rb][2:0];
                OP_LI:    model_regs[1] = sign_extend(w[5:0]);
                OP_LOAD:  model_regs[rb] = model_mem[model_regs[ra]];
                OP_STORE: model_mem[model_regs[ra]] = model_regs[rb];
                OP_BRANCH: begin
                    if (&w[5:0]) begin
                        halted = 1'b1; // All-ones offset
                    end else if (model_regs[1] == 8'd0) begin
                        next_pc = pc + 8'd1 + sign_extend(w[5:0]);
                    end
                end
            endcase
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic run_program();
        load_program();
        start_run();
        wait_done();
        run_model();
    endtask

    task automatic read_registers();
        logic [31:0] value;
        logic [1:0]  r;
        for (int i = 0; i < 4; i++) begin
            axi_read(REG_R0 + 8'(4 * i), value, r);
            hw_regs[i] = value[DATA_W-1:0];
            expect_equal($sformatf("r%0d", i), 32'(model_regs[i]), value);
            expect_equal("rresp", 32'(RESP_OKAY), 32'(r));
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("Test %0d %s: %s", tests, name, (test_errors == 0) ? "ok" : "failed");
        test_errors = 0;
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = 4'hF; // Full-word writes
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        cycles        = 0;
        timeout_limit = 4000;
        errors        = 0;
        test_errors   = 0;
        checks        = 0;
        tests         = 0;
        failed_tests  = 0;
        rng           = 32'd23;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        axi_read(REG_CTRL, rd, resp);
        expect_equal("ctrl", 32'd0, rd);
        expect_equal("rresp", 32'(RESP_OKAY), 32'(resp));
        axi_read(8'h40, rd, resp); // Unmapped
        expect_equal("rdata", 32'd0, rd);
        expect_equal("rresp", 32'(RESP_SLVERR), 32'(resp));
        axi_write(8'h24, 32'hA5, resp);
        expect_equal("bresp", 32'(RESP_SLVERR), 32'(resp));
        end_test("reset and unmapped access");

        rng   = xorshift32(rng);
        x_imm = rng[5:0];
        rng   = xorshift32(rng);
        y_imm = rng[5:0];
        prog.delete();
        prog.push_back(encode_imm(OP_LI, x_imm));
        copy_r1_to(2'd2);
        prog.push_back(encode_imm(OP_LI, y_imm));
        copy_r1_to(2'd3);
        prog.push_back(encode_reg(OP_ADD, 2'd2, 2'd3));
        prog.push_back(encode_reg(OP_SHL, 2'd1, 2'd3));
        prog.push_back(encode_reg(OP_SUB, 2'd1, 2'd2));
        prog.push_back(encode_reg(OP_AND, 2'd1, 2'd3));
        prog.push_back(encode_imm(OP_BRANCH, 6'h3F)); // HALT
        run_program();
        read_registers();
        expect_equal("done", 32'd1, 32'(done));
        axi_read(REG_CTRL, rd, resp);
        expect_equal("ctrl", 32'd2, rd); // Done 1, busy 0
        end_test("arithmetic");

        prog.delete();
        prog.push_back(encode_imm(OP_LI, 6'h20)); // -32
        copy_r1_to(2'd2);
        prog.push_back(encode_imm(OP_LI, 6'h3F)); // -1
        copy_r1_to(2'd3);
        prog.push_back(encode_imm(OP_LI, 6'h2A)); // -22
        prog.push_back(encode_imm(OP_BRANCH, 6'h3F));
        run_program();
        read_registers();
        expect_equal("r1", 32'hEA, 32'(hw_regs[1]));
        expect_equal("r2", 32'hE0, 32'(hw_regs[2]));
        expect_equal("r3", 32'hFF, 32'(hw_regs[3]));
        end_test("sign extension");

        rng   = xorshift32(rng);
        x_imm = rng[5:0];
        prog.delete();
        prog.push_back(encode_imm(OP_LI, 6'd5));
        copy_r1_to(2'd2);                                 // r2 = 5 as address
        prog.push_back(encode_imm(OP_LI, x_imm));
        prog.push_back(encode_reg(OP_STORE, 2'd2, 2'd1)); // mem[5] = value
        prog.push_back(encode_imm(OP_LI, 6'd9));
        prog.push_back(encode_reg(OP_LOAD, 2'd2, 2'd3));  // r3 = mem[5]
        prog.push_back(encode_imm(OP_BRANCH, 6'h3F));
        run_program();
        read_registers();
        expect_equal("r3", 32'(sign_extend(x_imm)), 32'(hw_regs[3]));
        expect_equal("r1", 32'd9, 32'(hw_regs[1])); // Untouched by LOAD
        end_test("store and load");

        prog.delete();
        prog.push_back(encode_imm(OP_LI, 6'd6));
        prog.push_back(encode_reg(OP_STORE, 2'd0, 2'd1)); // mem[0] = 6
        prog.push_back(encode_imm(OP_LI, 6'd0));
        prog.push_back(encode_imm(OP_BRANCH, 6'd1));      // Taken
        prog.push_back(encode_reg(OP_LOAD, 2'd0, 2'd3));  // Skipped
        prog.push_back(encode_imm(OP_LI, 6'd3));
        prog.push_back(encode_imm(OP_BRANCH, 6'd1));      // Falls through
        prog.push_back(encode_reg(OP_LOAD, 2'd0, 2'd2));
        prog.push_back(encode_imm(OP_BRANCH, 6'h3F));
        load_program();
        axi_write(REG_PADDR, 32'd3, resp); // Aim at the taken branch
        expect_equal("bresp", 32'(RESP_OKAY), 32'(resp));
        start_run();
        axi_write(REG_PDATA, 32'(encode_imm(OP_LI, 6'd21)), resp);
        expect_equal("bresp", 32'(RESP_SLVERR), 32'(resp));
        axi_write(REG_CTRL, 32'd1, resp); // Restart attempt mid-run
        expect_equal("bresp", 32'(RESP_SLVERR), 32'(resp));
        wait_done();
        run_model();
        read_registers();
        expect_equal("r2", 32'd6, 32'(hw_regs[2]));
        start_run(); // Same program again
        wait_done();
        run_model();
        read_registers();
        end_test("branches and busy write");

        total_errors = errors + cpu9_top_i.host_regs_i.host_regs_sva_i.fail_count;
        $display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests, failed_tests, checks, errors,
                 cpu9_top_i.host_regs_i.host_regs_sva_i.fail_count);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/cpu9_tb_sva.sv
`timescale 1ns/100ps

module cpu9_tb_sva (
    input logic                        clk,
    input logic                        rst,
    input logic                        awready,
    input logic                        wready,
    input logic [1:0]                  bresp,
    input logic                        bvalid,
    input logic                        bready,
    input logic [cpu9_pkg::AXI_DW-1:0] rdata,
    input logic [1:0]                  rresp,
    input logic                        rvalid,
    input logic                        rready,
    input logic                        start,
    input logic                        busy
);

    int fail_count = 0; // Assertion failures so far

    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("bvalid dropped or bresp changed before bready");
            fail_count++;
        end

    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("rvalid dropped or read data changed before rready");
            fail_count++;
        end

    // One-cycle accept, response pending after it and no second accept
    no_accept: assert property (@(posedge clk) disable iff (rst)
        awready |=> bvalid && !awready && !wready)
        else begin
            $error("write accept not followed by a lone pending response");
            fail_count++;
        end

    start_idle: assert property (@(posedge clk) disable iff (rst)
        $rose(start) |-> !busy)
        else begin
            $error("start pulse while core busy");
            fail_count++;
        end

endmodule

bind host_regs cpu9_tb_sva host_regs_sva_i (
    .clk     (clk),
    .rst     (rst),
    .awready (awready),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .start   (start),
    .busy    (busy)
);

//--- source/cpu9_top.sv
`timescale 1ns/100ps

module cpu9_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cpu9_pkg::AXI_AW-1:0]      awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [cpu9_pkg::AXI_DW-1:0]      wdata,
    input  logic [cpu9_pkg::AXI_DW/8-1:0]    wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [cpu9_pkg::AXI_AW-1:0]      araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [cpu9_pkg::AXI_DW-1:0]      rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,
    output logic                             done
);

    import cpu9_pkg::*;

    logic            prog_we;   // Host program write
    logic [PC_W-1:0] prog_addr;
    instr_t          prog_data;
    logic            start;
    logic            busy;
    data_t [3:0]     reg_view;
    logic [PC_W-1:0] pc_fetch;  // Core fetch address
    instr_t          instr;

    host_regs host_regs_i (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .reg_view  (reg_view)
    );

    // Instruction memory, host writes, core reads
    sync_ram #(
        .word_t (instr_t),
        .DEPTH  (IMEM_DEPTH)
    ) imem_i (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (pc_fetch),
        .rdata (instr)
    );

    cpu9_core cpu9_core_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .instr    (instr),
        .pc_fetch (pc_fetch),
        .busy     (busy),
        .done     (done),
        .reg_view (reg_view)
    );

endmodule

//--- source/host_regs.sv
`timescale 1ns/100ps

module host_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [cpu9_pkg::AXI_AW-1:0]      awaddr,
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [cpu9_pkg::AXI_DW-1:0]      wdata,
    input  logic [cpu9_pkg::AXI_DW/8-1:0]    wstrb,
    input  logic                             wvalid,
    output logic                             wready,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic [cpu9_pkg::AXI_AW-1:0]      araddr,
    input  logic                             arvalid,
    output logic                             arready,
    output logic [cpu9_pkg::AXI_DW-1:0]      rdata,
    output logic [1:0]                       rresp,
    output logic                             rvalid,
    input  logic                             rready,
    output logic                             prog_we,
    output logic [cpu9_pkg::PC_W-1:0]        prog_addr,
    output cpu9_pkg::instr_t                 prog_data,
    output logic                             start,
    input  logic                             busy,
    input  logic                             done,
    input  cpu9_pkg::data_t [3:0]            reg_view
);

    import cpu9_pkg::*;

    logic              wr_hs;    // Write address and data accepted
    logic              rd_hs;    // Read address accepted
    logic              run_busy; // Core running or about to
    logic              wr_err;
    logic              rd_err;
    logic [AXI_DW-1:0] rd_word;

    // AW and W taken together, blocked while a response waits
    assign wr_hs   = awvalid & wvalid & ~bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign rd_hs   = arvalid & ~rvalid;
    assign arready = rd_hs;

    assign run_busy = busy | start; // Start pulse counts as running

    // Write decode
    always_comb begin
        case (awaddr)
            REG_CTRL, REG_PDATA: wr_err = run_busy; // Locked during a run
            REG_PADDR:           wr_err = 1'b0;
            default:             wr_err = 1'b1;     // Unmapped or read-only
        endcase
        if (wstrb != '1) begin
            wr_err = 1'b1; // Full-word writes only
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid    <= 1'b0;
            start     <= 1'b0;
            prog_we   <= 1'b0;
            prog_addr <= '0;
        end else begin
            start   <= 1'b0; // One-cycle pulses
            prog_we <= 1'b0;
            if (prog_we) begin
                prog_addr <= prog_addr + 1'b1; // Step after each instruction write
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_hs) begin
                bvalid <= 1'b1;
                if (!wr_err) begin
                    case (awaddr)
                        REG_CTRL:  start     <= wdata[0];
                        REG_PADDR: prog_addr <= wdata[PC_W-1:0];
                        REG_PDATA: prog_we   <= 1'b1;
                        default:   prog_we   <= 1'b0;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp     <= wr_err ? RESP_SLVERR : RESP_OKAY;
            prog_data <= wdata[INSTR_W-1:0]; // Only written out on a PDATA hit
        end
    end

    // Read mux
    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        case (araddr)
            REG_CTRL:  rd_word = {{(AXI_DW-2){1'b0}}, done, busy};
            REG_PADDR: rd_word = AXI_DW'(prog_addr);
            REG_R0:    rd_word = AXI_DW'(reg_view[0]);
            REG_R1:    rd_word = AXI_DW'(reg_view[1]);
            REG_R2:    rd_word = AXI_DW'(reg_view[2]);
            REG_R3:    rd_word = AXI_DW'(reg_view[3]);
            default:   rd_err  = 1'b1; // Zero data with SLVERR
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0; // Held until the host takes it
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= rd_word; // Captured once, stable while rvalid
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

//--- source/cpu9_core.sv
`timescale 1ns/100ps

module cpu9_core (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  cpu9_pkg::instr_t             instr,
    output logic [cpu9_pkg::PC_W-1:0]    pc_fetch,
    output logic                         busy,
    output logic                         done,
    output cpu9_pkg::data_t [3:0]        reg_view
);

    import cpu9_pkg::*;

    run_state_t      state;
    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] pc_plus1;
    logic [PC_W-1:0] pc_next;

    opcode_t          opcode;
    logic [1:0]       r_a;
    logic [1:0]       r_b;
    logic [IMM_W-1:0] imm;
    data_t            imm_ext;

    data_t   data_a;
    data_t   data_b;
    data_t   data_r1;
    data_t   alu_b;
    data_t   alu_out;
    alu_op_t alu_op;
    logic    zero;

    logic  is_alu;
    logic  is_load;
    logic  is_halt;
    logic  rf_we;
    logic  [1:0] rf_waddr;
    data_t rf_wdata;
    logic  dmem_we;
    data_t dmem_rdata;

    // Instruction fields
    assign opcode  = opcode_t'(instr[8:6]);
    assign r_a     = instr[5:4];
    assign r_b     = instr[3:2];
    assign imm     = instr[IMM_W-1:0];
    assign imm_ext = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm}; // Sign extend

    assign is_alu  = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_SHL, OP_LI};
    assign is_load = (opcode == OP_LOAD);
    assign is_halt = (opcode == OP_BRANCH) && (imm == HALT_IMM);

    // Operand routing and ALU op select
    always_comb begin
        alu_b = data_b; // Register B by default
        case (opcode)
            OP_ADD: alu_op = ALU_ADD;
            OP_SUB: alu_op = ALU_SUB;
            OP_AND: alu_op = ALU_AND;
            OP_SHL: alu_op = ALU_SHL;
            OP_LI: begin
                alu_op = ALU_PASS_B;
                alu_b  = imm_ext; // Immediate rides the B side
            end
            OP_BRANCH: begin
                alu_op = ALU_PASS_B;
                alu_b  = data_r1; // Zero flag tests r1
            end
            default: alu_op = ALU_PASS_B;
        endcase
    end

    // Next PC, wraps at 256
    assign pc_plus1 = pc + 1'b1;
    assign pc_next  = (opcode == OP_BRANCH && zero) ? pc_plus1 + imm_ext : pc_plus1;

    // Write-back select, r1 default, rB on load
    assign rf_we    = (state == ST_EXEC && is_alu) || (state == ST_WBACK);
    assign rf_waddr = (state == ST_WBACK) ? r_b : 2'd1;
    assign rf_wdata = (state == ST_WBACK) ? dmem_rdata : alu_out;
    assign dmem_we  = (state == ST_EXEC) && (opcode == OP_STORE);

    // Run sequence
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_HALTED: begin
                    if (start) begin
                        state <= ST_FETCH;
                        pc    <= '0; // Every run starts at address 0
                    end
                end
                ST_FETCH: state <= ST_EXEC; // Instruction memory read in flight
                ST_EXEC: begin
                    if (is_halt) begin
                        state <= ST_HALTED;
                    end else begin
                        pc    <= pc_next;
                        state <= is_load ? ST_WBACK : ST_FETCH;
                    end
                end
                ST_WBACK: state <= ST_FETCH; // Load data lands in rB
                default:  state <= ST_IDLE;
            endcase
        end
    end

    assign pc_fetch = pc;
    assign busy     = state inside {ST_FETCH, ST_EXEC, ST_WBACK};
    assign done     = (state == ST_HALTED); // High the cycle after HALT

    register_file register_file_i (
        .clk     (clk),
        .rst     (rst),
        .ra      (r_a),
        .rb      (r_b),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .data_a  (data_a),
        .data_b  (data_b),
        .data_r1 (data_r1),
        .view    (reg_view)
    );

    alu alu_i (
        .a      (data_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_out),
        .zero   (zero)
    );

    // Data memory, address from register A
    sync_ram #(
        .word_t (data_t),
        .DEPTH  (DMEM_DEPTH)
    ) dmem_i (
        .clk   (clk),
        .we    (dmem_we),
        .waddr (data_a),
        .wdata (data_b),
        .raddr (data_a),
        .rdata (dmem_rdata)
    );

endmodule

//--- source/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [1:0]            ra,
    input  logic [1:0]            rb,
    input  logic                  we,
    input  logic [1:0]            waddr,
    input  cpu9_pkg::data_t       wdata,
    output cpu9_pkg::data_t       data_a,
    output cpu9_pkg::data_t       data_b,
    output cpu9_pkg::data_t       data_r1,
    output cpu9_pkg::data_t [3:0] view
);

    import cpu9_pkg::*;

    data_t [3:0] regs; // r0..r3

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0; // All registers clear
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign data_a  = regs[ra]; // Combinational read ports
    assign data_b  = regs[rb];
    assign data_r1 = regs[1];  // Branch condition source
    assign view    = regs;     // Host readback

endmodule

//--- source/alu.sv
`timescale 1ns/100ps

module alu (
    input  cpu9_pkg::data_t   a,
    input  cpu9_pkg::data_t   b,
    input  cpu9_pkg::alu_op_t op,
    output cpu9_pkg::data_t   result,
    output logic              zero
);

    import cpu9_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;       // Wraps at 8 bits
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_SHL:    result = a << b[2:0]; // Shift amount modulo 8
            ALU_PASS_B: result = b;           // LI and branch path
            default:    result = '0;
        endcase
    end

    // Branch test, B carries r1 for branches
    assign zero = (b == '0);

endmodule

//--- source/sync_ram.sv
`timescale 1ns/100ps

module sync_ram #(
    parameter type word_t = logic [7:0], // Payload type
    parameter int  DEPTH  = 256
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_t                    rdata
);

    word_t mem [DEPTH]; // Storage array

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata; // Write on the edge
        end
        rdata <= mem[raddr]; // Read data one cycle after address
    end

endmodule

//--- source/cpu9_pkg.sv
package cpu9_pkg;

    localparam int DATA_W     = 8;   // Data and register width
    localparam int INSTR_W    = 9;   // Instruction width
    localparam int PC_W       = 8;   // Program counter width
    localparam int IMEM_DEPTH = 256; // Instruction words
    localparam int DMEM_DEPTH = 256; // Data bytes
    localparam int IMM_W      = 6;   // Immediate field width

    localparam int AXI_AW = 8;  // Host address width
    localparam int AXI_DW = 32; // Host data width

    typedef logic [INSTR_W-1:0] instr_t; // [8:6] op, [5:4] ra, [3:2] rb, [5:0] imm
    typedef logic [DATA_W-1:0]  data_t;

    typedef enum logic [2:0] {
        OP_ADD    = 3'd0, // r1 = A + B
        OP_SUB    = 3'd1, // r1 = A - B
        OP_AND    = 3'd2, // r1 = A & B
        OP_SHL    = 3'd3, // r1 = A << B[2:0]
        OP_LI     = 3'd4, // r1 = sext(imm)
        OP_LOAD   = 3'd5, // rB = mem[A]
        OP_STORE  = 3'd6, // mem[A] = rB
        OP_BRANCH = 3'd7  // Taken when r1 is zero
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_SHL    = 3'd3,
        ALU_PASS_B = 3'd4
    } alu_op_t;

    localparam logic [IMM_W-1:0] HALT_IMM = '1; // Branch with this offset halts

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_WBACK,
        ST_HALTED
    } run_state_t;

    // Host register map
    localparam logic [AXI_AW-1:0] REG_CTRL  = 8'h00; // W: bit0 start, R: bit0 busy, bit1 done
    localparam logic [AXI_AW-1:0] REG_PADDR = 8'h04; // Program load address
    localparam logic [AXI_AW-1:0] REG_PDATA = 8'h08; // Instruction write, address increments
    localparam logic [AXI_AW-1:0] REG_R0    = 8'h10;
    localparam logic [AXI_AW-1:0] REG_R1    = 8'h14;
    localparam logic [AXI_AW-1:0] REG_R2    = 8'h18;
    localparam logic [AXI_AW-1:0] REG_R3    = 8'h1C;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
